//--- Makefile
# Verilator build and run of the AHB to APB bridge testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_ahb_apb_bridge
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Test failures found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported failures, see $(LOG)"; \
	  exit 1; \
	fi
	@echo "Simulation finished without failures"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- ahb_apb_bridge.sv
// AHB to APB bridge on a single clock, one transfer in flight
// Zero-wait APB access holds hready low for three cycles
// hresp is not provided, unmapped addresses wait forever on pready
`timescale 1ns/1ps

`include "bridge_cfg.svh"

module ahb_apb_bridge
  import bridge_pkg::*;
(
  // AHB side
  input  logic        hclk21,
  input  logic        hreset_n21,
  input  logic        hsel,
  input  addr_t       haddr,
  input  htrans_e     htrans,
  input  logic        hwrite,
  input  data_t       hwdata,
  output data_t       hrdata,
  output logic        hready,

  // APB signals common to all slots
  output addr_t       paddr,
  output logic        pwrite,
  output data_t       pwdata,
  output logic        penable,

  // Per-slot APB signals
  output slave_vec_t  psel,
  input  slave_vec_t  pready,
  input  slave_data_t prdata
);

  logic        accept;
  apb_state_e  apb_state;
  slave_vec_t  slot_ready;
  slave_data_t slot_rdata;

  bridge_xfer_if xfer_if ();

  // --------------------------------------------------
  // AHB front end
  // --------------------------------------------------
  ahb_front_end u_front_end (
    .hclk21     (hclk21),
    .hreset_n21 (hreset_n21),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hready     (hready),
    .hrdata     (hrdata),
    .accept     (accept),
    .xfer       (xfer_if.front)
  );

  // --------------------------------------------------
  // Slave slots
  // --------------------------------------------------
  for (genvar i = 0; i < `BRIDGE_NUM_SLAVES; i++) begin : g_slot
    apb_slot #(
      .slot_index (i)
    ) u_slot (
      .hclk21     (hclk21),
      .hreset_n21 (hreset_n21),
      .accept     (accept),
      .haddr      (haddr),
      .apb_state  (apb_state),
      .psel       (psel[i]),
      .pready     (pready[i]),
      .prdata     (prdata[i]),
      .slot_ready (slot_ready[i]),
      .slot_rdata (slot_rdata[i])
    );
  end

  // --------------------------------------------------
  // APB sequencer
  // --------------------------------------------------
  apb_sequencer u_sequencer (
    .hclk21     (hclk21),
    .hreset_n21 (hreset_n21),
    .xfer       (xfer_if.seq),
    .slot_ready (slot_ready),
    .slot_rdata (slot_rdata),
    .apb_state  (apb_state),
    .paddr      (paddr),
    .pwrite     (pwrite),
    .penable    (penable)
  );

  // Master holds hwdata through the data phase, so no capture needed
  assign pwdata = hwdata;

endmodule

//--- ahb_front_end.sv
// AHB slave side of the bridge, one outstanding transfer at a time
// hready stays low from the accepting edge until the sequencer signals done
// hrdata is loaded on every completion, writes included
`timescale 1ns/1ps

module ahb_front_end
  import bridge_pkg::*;
(
  input  logic    hclk21,
  input  logic    hreset_n21,
  input  logic    hsel,
  input  addr_t   haddr,
  input  htrans_e htrans,
  input  logic    hwrite,
  output logic    hready,
  output data_t   hrdata,
  output logic    accept,
  bridge_xfer_if.front xfer
);

  logic  valid_trans;
  logic  data_phase;
  addr_t addr_q;
  logic  write_q;

  // --------------------------------------------------
  // Transfer qualification
  // --------------------------------------------------

  // Only NONSEQ and SEQ start work, IDLE and BUSY are ignored
  assign valid_trans = hsel && ((htrans == NONSEQ) || (htrans == SEQ));

  // Accept only while the bus is in the address phase
  assign accept = valid_trans && !data_phase;

  assign hready = !data_phase;

  // --------------------------------------------------
  // Phase tracking and read data
  // --------------------------------------------------
  always_ff @(posedge hclk21 or negedge hreset_n21) begin
    if (!hreset_n21) begin
      data_phase <= 1'b0;
      hrdata     <= '0;
    end else begin
      if (accept) begin
        data_phase <= 1'b1;
      end else if (xfer.done) begin
        data_phase <= 1'b0;
        hrdata     <= xfer.rdata;
      end
    end
  end

  // Address and direction held for the sequencer
  always_ff @(posedge hclk21) begin
    if (accept) begin
      addr_q  <= haddr;
      write_q <= hwrite;
    end
  end

  assign xfer.pending = data_phase;
  assign xfer.addr    = addr_q;
  assign xfer.write   = write_q;

endmodule

//--- apb_sequencer.sv
// APB master state machine, IDLE then SETUP then ACCESS then back to IDLE
// Every transfer returns to IDLE before the next one starts
// done and rdata are combinational in the completing ACCESS cycle
`timescale 1ns/1ps

module apb_sequencer
  import bridge_pkg::*;
(
  input  logic        hclk21,
  input  logic        hreset_n21,
  bridge_xfer_if.seq  xfer,
  input  slave_vec_t  slot_ready,
  input  slave_data_t slot_rdata,
  output apb_state_e  apb_state,
  output addr_t       paddr,
  output logic        pwrite,
  output logic        penable
);

  apb_state_e state;
  logic       ready_any;
  data_t      rdata_any;

  // --------------------------------------------------
  // Slot drain
  // --------------------------------------------------

  // Unselected slots drive zero, so a plain OR acts as the mux
  assign ready_any = |slot_ready;

  always_comb begin
    data_t acc;
    acc = '0;
    for (int i = 0; i < $bits(slave_vec_t); i++) begin
      acc = acc | slot_rdata[i];
    end
    rdata_any = acc;
  end

  // Completion pulse back to the front end
  assign xfer.done  = (state == APB_ACCESS) && ready_any;
  assign xfer.rdata = rdata_any;

  // --------------------------------------------------
  // State machine
  // --------------------------------------------------
  always_ff @(posedge hclk21 or negedge hreset_n21) begin
    if (!hreset_n21) begin
      state   <= APB_IDLE;
      penable <= 1'b0;
      paddr   <= '0;
      pwrite  <= 1'b0;
    end else begin
      case (state)
        APB_IDLE: begin
          if (xfer.pending) begin
            state  <= APB_SETUP;
            paddr  <= xfer.addr;
            pwrite <= xfer.write;
          end
        end
        APB_SETUP: begin
          state   <= APB_ACCESS;
          penable <= 1'b1;
        end
        APB_ACCESS: begin
          // Wait states simply hold here
          if (ready_any) begin
            state   <= APB_IDLE;
            penable <= 1'b0;
          end
        end
        default: begin
          state   <= APB_IDLE;
          penable <= 1'b0;
        end
      endcase
    end
  end

  assign apb_state = state;

endmodule

//--- apb_slot.sv
// One APB slave slot of the fixed address map
// slot_index must be below the slot count from the cfg header
// The window match is taken on accept and held until the next accept
`timescale 1ns/1ps

`include "bridge_cfg.svh"

module apb_slot
  import bridge_pkg::*;
#(
  parameter int slot_index = 0
) (
  input  logic       hclk21,
  input  logic       hreset_n21,
  input  logic       accept,
  input  addr_t      haddr,
  input  apb_state_e apb_state,
  output logic       psel,
  input  logic       pready,
  input  data_t      prdata,
  output logic       slot_ready,
  output data_t      slot_rdata
);

  // Lower bound of this slot's window
  localparam addr_t slot_base = addr_t'(`BRIDGE_SLAVE_BASE + slot_index * `BRIDGE_SLAVE_SPAN);

  addr_t offset;
  logic  in_window;
  logic  match;

  // Unsigned offset, so anything below the base wraps high and misses
  assign offset    = haddr - slot_base;
  assign in_window = (offset < addr_t'(`BRIDGE_SLAVE_SPAN));

  always_ff @(posedge hclk21 or negedge hreset_n21) begin
    if (!hreset_n21) begin
      match <= 1'b0;
    end else if (accept) begin
      match <= in_window;
    end
  end

  // Selected through SETUP and ACCESS
  assign psel = match && (apb_state != APB_IDLE);

  // Zero when not selected so the sequencer can OR all slots
  assign slot_ready = psel && pready;
  assign slot_rdata = psel ? prdata : '0;

endmodule

//--- bridge_cfg.svh
// Bridge build constants shared by the package and the RTL
// Slot i decodes BASE + i*SPAN up to the next window, SPAN bytes each
// Addresses outside the slot windows are not decoded
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// --------------------------------------------------
// Slave slots
// --------------------------------------------------
`define BRIDGE_NUM_SLAVES 4

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

// --------------------------------------------------
// Address map
// --------------------------------------------------
`define BRIDGE_SLAVE_BASE 32'h4000_0000
`define BRIDGE_SLAVE_SPAN 32'h0000_1000

`endif

//--- bridge_pkg.sv
// Types shared by the bridge RTL and its testbench
// Widths and slot count come from the cfg header
`include "bridge_cfg.svh"

package bridge_pkg;

  // Bus words
  typedef logic [`BRIDGE_ADDR_W-1:0] addr_t;
  typedef logic [`BRIDGE_DATA_W-1:0] data_t;

  // One bit or one word per slave slot
  typedef logic [`BRIDGE_NUM_SLAVES-1:0] slave_vec_t;
  typedef data_t [`BRIDGE_NUM_SLAVES-1:0] slave_data_t;

  // AHB transfer type, encoded as on the bus
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // APB sequencer states
  typedef enum logic [1:0] {
    APB_IDLE   = 2'b00,
    APB_SETUP  = 2'b01,
    APB_ACCESS = 2'b10
  } apb_state_e;

endpackage

//--- bridge_xfer_if.sv
// Hand-over of one pending transfer from the AHB front end to the APB sequencer
// pending rises on the accepting edge and holds until the edge where done is high
// addr and write stay stable while pending is high
`timescale 1ns/1ps

interface bridge_xfer_if
  import bridge_pkg::*;
();

  // Front end side
  logic  pending;
  addr_t addr;
  logic  write;

  // Sequencer side, done is a single-cycle pulse
  logic  done;
  data_t rdata;

  modport front (
    output pending,
    output addr,
    output write,
    input  done,
    input  rdata
  );

  modport seq (
    input  pending,
    input  addr,
    input  write,
    output done,
    output rdata
  );

endinterface

//--- src.f
+incdir+.
bridge_pkg.sv
bridge_xfer_if.sv
ahb_front_end.sv
apb_slot.sv
apb_sequencer.sv
ahb_apb_bridge.sv
tb_ahb_apb_bridge.sv

//--- tb_ahb_apb_bridge.sv
// Random AHB traffic against model APB slaves that insert 0 to 3 wait states
// Addresses stay inside the slot windows since an unmapped one would stall the bridge
// Read data is predicted by a reference memory where unwritten words read as zero
`timescale 1ns/1ps

`include "bridge_cfg.svh"

module tb_ahb_apb_bridge
  import bridge_pkg::*;
();

  localparam int NUM_TRANSFERS  = 200;
  localparam int NUM_BATCHES    = 4;
  localparam int RESET_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = NUM_TRANSFERS * 10 + 100;
  localparam int WORDS_PER_SLOT = `BRIDGE_SLAVE_SPAN / 4;
  // Few offsets per slot, so reads often hit written words
  localparam int USED_WORDS     = 16;

  logic        hclk21;
  logic        hreset_n21;
  logic        hsel;
  addr_t       haddr;
  htrans_e     htrans;
  logic        hwrite;
  data_t       hwdata;
  data_t       hrdata;
  logic        hready;
  addr_t       paddr;
  logic        pwrite;
  data_t       pwdata;
  logic        penable;
  slave_vec_t  psel;
  slave_vec_t  pready;
  slave_data_t prdata;

  data_t slave_mem [`BRIDGE_NUM_SLAVES][WORDS_PER_SLOT];
  int    wait_left [`BRIDGE_NUM_SLAVES];
  int    waits_drawn;
  data_t ref_mem [addr_t];

  int cycle_count;
  int test_errors;
  int total_errors;
  int tests_run;
  int tests_failed;

  ahb_apb_bridge dut (
    .hclk21     (hclk21),
    .hreset_n21 (hreset_n21),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hwdata     (hwdata),
    .hrdata     (hrdata),
    .hready     (hready),
    .paddr      (paddr),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .penable    (penable),
    .psel       (psel),
    .pready     (pready),
    .prdata     (prdata)
  );

  always #20 hclk21 = ~hclk21;

  always @(posedge hclk21) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR: timeout after %0d cycles, the bridge stopped responding", cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

  // Start of the window that slot s decodes
  function automatic addr_t window_base(input int s);
    return `BRIDGE_SLAVE_BASE + addr_t'(s) * `BRIDGE_SLAVE_SPAN;
  endfunction

  // --------------------------------------------------
  // Model APB slaves driven 1 ns after each edge
  // --------------------------------------------------
  always @(posedge hclk21) begin
    int word;
    #1;
    for (int s = 0; s < `BRIDGE_NUM_SLAVES; s++) begin
      if (psel[s] && !penable) begin
        // Wait states for this access are picked in SETUP
        wait_left[s] = int'($urandom % 4);
        waits_drawn  = wait_left[s];
        pready[s]    = 1'b0;
        prdata[s]    = $urandom;
      end else if (psel[s] && penable) begin
        if (wait_left[s] == 0) begin
          word      = int'((paddr - window_base(s)) >> 2);
          pready[s] = 1'b1;
          prdata[s] = $urandom;
          if (pwrite) begin
            slave_mem[s][word] = pwdata;
          end else begin
            prdata[s] = slave_mem[s][word];
          end
        end else begin
          wait_left[s]--;
          pready[s] = 1'b0;
          prdata[s] = $urandom;
        end
      end else begin
        // Unselected slots toggle freely and the bridge must gate them
        pready[s] = 1'($urandom % 2);
        prdata[s] = $urandom;
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    test_errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR: %s at %0t", msg, $time);
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, test_errors);
    end else begin
      $display("test %s: passed", name);
    end
    test_errors = 0;
  endtask

  task automatic check_reset_outputs();
    if (hready !== 1'b1) report_mismatch("hready", 32'(hready), 1);
    if (psel !== '0) report_mismatch("psel", 32'(psel), 0);
    if (penable !== 1'b0) report_mismatch("penable", 32'(penable), 0);
    if (hrdata !== '0) report_mismatch("hrdata", hrdata, 0);
    if (paddr !== '0) report_mismatch("paddr", paddr, 0);
    if (pwrite !== 1'b0) report_mismatch("pwrite", 32'(pwrite), 0);
  endtask

  // One cycle that must not start an APB transfer
  task automatic ignored_cycle();
    int kind;
    kind   = int'($urandom % 3);
    haddr  = window_base(int'($urandom % `BRIDGE_NUM_SLAVES)) +
             addr_t'(($urandom % USED_WORDS) * 4);
    hwrite = 1'($urandom % 2);
    hsel   = (kind != 0);
    htrans = (kind == 1) ? IDLE : ((kind == 2) ? BUSY : NONSEQ);
    @(posedge hclk21);
    #1;
    if (psel !== '0) report_mismatch("psel", 32'(psel), 0);
    if (hready !== 1'b1) report_mismatch("hready", 32'(hready), 1);
  endtask

  task automatic run_transfer(input int slot, input int word, input logic write);
    addr_t      addr;
    data_t      wdata;
    data_t      expected;
    slave_vec_t sel_exp;
    int         low_cycles;
    addr    = window_base(slot) + addr_t'(word * 4);
    wdata   = $urandom;
    sel_exp = slave_vec_t'(1) << slot;
    hsel    = 1'b1;
    htrans  = ($urandom % 2) ? NONSEQ : SEQ;
    haddr   = addr;
    hwrite  = write;
    hwdata  = wdata;
    @(posedge hclk21);
    #1;
    // The bus idles behind the data phase while hwdata is held
    hsel       = 1'b0;
    htrans     = IDLE;
    low_cycles = 0;
    while (hready == 1'b0) begin
      low_cycles++;
      if (low_cycles == 1 && psel !== '0) report_mismatch("psel", 32'(psel), 0);
      if (low_cycles == 2) begin
        if (psel !== sel_exp) report_mismatch("psel", 32'(psel), 32'(sel_exp));
        if (penable !== 1'b0) report_mismatch("penable", 32'(penable), 0);
        if (paddr !== addr) report_mismatch("paddr", paddr, addr);
        if (pwrite !== write) report_mismatch("pwrite", 32'(pwrite), 32'(write));
        if (write && pwdata !== wdata) report_mismatch("pwdata", pwdata, wdata);
      end
      if (low_cycles == 3) begin
        if (psel !== sel_exp) report_mismatch("psel", 32'(psel), 32'(sel_exp));
        if (penable !== 1'b1) report_mismatch("penable", 32'(penable), 1);
      end
      @(posedge hclk21);
      #1;
    end
    if (low_cycles != 3 + waits_drawn) begin
      report_problem($sformatf("hready was low for %0d cycles instead of %0d",
                               low_cycles, 3 + waits_drawn));
    end
    if (write) begin
      ref_mem[addr] = wdata;
    end else begin
      expected = ref_mem.exists(addr) ? ref_mem[addr] : '0;
      if (hrdata !== expected) report_mismatch("hrdata", hrdata, expected);
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(32'ha9b8136b));
    hclk21       = 1'b0;
    hreset_n21   = 1'b0;
    hsel         = 1'b0;
    haddr        = '0;
    htrans       = IDLE;
    hwrite       = 1'b0;
    hwdata       = '0;
    pready       = '0;
    prdata       = '0;
    waits_drawn  = 0;
    cycle_count  = 0;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int s = 0; s < `BRIDGE_NUM_SLAVES; s++) begin
      wait_left[s] = 0;
      for (int w = 0; w < WORDS_PER_SLOT; w++) begin
        slave_mem[s][w] = '0;
      end
    end

    repeat (RESET_CYCLES) begin
      @(posedge hclk21);
      #1;
      check_reset_outputs();
    end
    hreset_n21 = 1'b1;
    @(posedge hclk21);
    #1;
    check_reset_outputs();
    finish_test("reset");

    for (int b = 0; b < NUM_BATCHES; b++) begin
      for (int t = 0; t < NUM_TRANSFERS / NUM_BATCHES; t++) begin
        repeat ($urandom % 3) ignored_cycle();
        run_transfer(int'($urandom % `BRIDGE_NUM_SLAVES), int'($urandom % USED_WORDS),
                     1'($urandom % 2));
      end
      finish_test($sformatf("traffic_%0d", b));
    end

    $display("tests run %0d, passed %0d, failed %0d, total errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
